// ==== source/sercore_cfg_pkg.sv ====
`default_nettype none

package sercore_cfg_pkg;

   // Data word width
   localparam int XLEN = 32;

   // Serial bit counter, 2**CNT_W cycles per instruction
   localparam int CNT_W = 5;

   // Register file address width
   localparam int REG_AW = 5;

endpackage

`default_nettype wire

// ==== source/sercore_isa_pkg.sv ====
`default_nettype none

package sercore_isa_pkg;

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;

   localparam logic [6:0] F7_SUB = 7'b0100000;

   // One instruction word, three ways of reading it
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm12;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
      struct packed {
         logic [19:0] imm20;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } u;
   } instr_u;

endpackage

`default_nettype wire

// ==== source/sercore_state.sv ====
`timescale 1ns/1ps
`default_nettype none

module sercore_state (
   input  wire  clk,
   input  wire  i_arst_n,
   input  wire  i_ibus_ack,
   input  wire  i_rf_ready,
   input  wire  i_cnt_done,
   input  wire  i_rd_write,
   output logic o_ibus_cyc,
   output logic o_rf_rreq,
   output logic o_cnt_start,
   output logic o_rd_en
);

   localparam logic [1:0] S_FETCH = 2'd0;
   localparam logic [1:0] S_REQ   = 2'd1;
   localparam logic [1:0] S_WAIT  = 2'd2;
   localparam logic [1:0] S_EXEC  = 2'd3;

   logic [1:0] state;
   logic [1:0] state_nxt;
   logic       cyc;
   logic       cyc_nxt;

   always_comb begin
      state_nxt = state;
      cyc_nxt   = cyc;
      case (state)
         S_FETCH: begin
            cyc_nxt = 1'b1;
            // Ack only counts while the bus cycle is up
            if (cyc && i_ibus_ack) begin
               state_nxt = S_REQ;
               cyc_nxt   = 1'b0;
            end
         end
         S_REQ: begin
            state_nxt = i_rf_ready ? S_EXEC : S_WAIT;
         end
         S_WAIT: begin
            if (i_rf_ready) begin
               state_nxt = S_EXEC;
            end
         end
         default: begin
            // Bit 31 done, fetch again right away
            if (i_cnt_done) begin
               state_nxt = S_FETCH;
               cyc_nxt   = 1'b1;
            end
         end
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= S_FETCH;
         cyc   <= 1'b0;
      end else begin
         state <= state_nxt;
         cyc   <= cyc_nxt;
      end
   end

   assign o_ibus_cyc  = cyc;
   assign o_rf_rreq   = (state == S_REQ);
   assign o_cnt_start = i_rf_ready && ((state == S_REQ) || (state == S_WAIT));
   assign o_rd_en     = (state == S_EXEC) && i_rd_write;

endmodule

`default_nettype wire

// ==== source/sercore_count.sv ====
`timescale 1ns/1ps
`default_nettype none

module sercore_count (
   input  wire  clk,
   input  wire  i_arst_n,
   input  wire  i_start,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_cnt2,
   output logic o_cnt_done
);

   logic                              en;
   logic [sercore_cfg_pkg::CNT_W-1:0] cnt;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         en  <= 1'b0;
         cnt <= '0;
      end else if (i_start) begin
         en  <= 1'b1;
         cnt <= '0;
      end else if (en) begin
         // Wraps back to zero on the last bit
         cnt <= cnt + 1'b1;
         if (&cnt) begin
            en <= 1'b0;
         end
      end
   end

   assign o_cnt_en   = en;
   assign o_cnt0     = en && (cnt == '0);
   assign o_cnt2     = en && (cnt == sercore_cfg_pkg::CNT_W'(2));
   assign o_cnt_done = en && (&cnt);

endmodule

`default_nettype wire

// ==== source/sercore_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module sercore_decode (
   input  wire                                 clk,
   input  wire                                 i_arst_n,
   input  wire                                 i_ibus_ack,
   input  wire  [sercore_cfg_pkg::XLEN-1:0]    i_ibus_rdt,
   input  wire                                 i_cnt_en,
   output logic [sercore_cfg_pkg::REG_AW-1:0]  o_rs1_addr,
   output logic [sercore_cfg_pkg::REG_AW-1:0]  o_rs2_addr,
   output logic [sercore_cfg_pkg::REG_AW-1:0]  o_rd_addr,
   output logic                                o_op_b_imm,
   output logic                                o_alu_sub,
   output logic [1:0]                          o_alu_bool_op,
   output logic [1:0]                          o_rd_sel,
   output logic                                o_jump,
   output logic                                o_rd_write,
   output logic                                o_imm
);

   localparam int XLEN = sercore_cfg_pkg::XLEN;

   sercore_isa_pkg::instr_u rdt;
   sercore_isa_pkg::instr_u instr;
   logic [XLEN-1:0]         imm_ld;
   logic [XLEN-1:0]         imm_sr;
   logic                    is_op;
   logic                    is_op_imm;
   logic                    is_lui;
   logic                    is_jal;
   logic                    f3_ok;
   logic                    f7_ok;

   assign rdt = i_ibus_rdt;

   // Immediate of the word on the bus
   always_comb begin
      case (rdt.r.opcode)
         sercore_isa_pkg::OPC_OP_IMM: imm_ld = {{(XLEN-12){rdt.i.imm12[11]}}, rdt.i.imm12};
         sercore_isa_pkg::OPC_LUI:    imm_ld = {rdt.u.imm20, 12'h000};
         sercore_isa_pkg::OPC_JAL:    imm_ld = {{(XLEN-20){rdt.u.imm20[19]}}, rdt.u.imm20[7:0],
                                                rdt.u.imm20[8], rdt.u.imm20[18:9], 1'b0};
         default:                     imm_ld = '0;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         instr <= '0;
      end else if (i_ibus_ack) begin
         instr <= rdt;
      end
   end

   // LSB first, one bit per execute cycle
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_sr <= imm_ld;
      end else if (i_cnt_en) begin
         imm_sr <= {1'b0, imm_sr[XLEN-1:1]};
      end
   end

   assign is_op     = (instr.r.opcode == sercore_isa_pkg::OPC_OP);
   assign is_op_imm = (instr.r.opcode == sercore_isa_pkg::OPC_OP_IMM);
   assign is_lui    = (instr.r.opcode == sercore_isa_pkg::OPC_LUI);
   assign is_jal    = (instr.r.opcode == sercore_isa_pkg::OPC_JAL);

   // 0 add, 1 xor, 2 or, 3 and
   always_comb begin
      f3_ok = 1'b1;
      case (instr.r.funct3)
         sercore_isa_pkg::F3_ADD: o_alu_bool_op = 2'd0;
         sercore_isa_pkg::F3_XOR: o_alu_bool_op = 2'd1;
         sercore_isa_pkg::F3_OR:  o_alu_bool_op = 2'd2;
         sercore_isa_pkg::F3_AND: o_alu_bool_op = 2'd3;
         default: begin
            o_alu_bool_op = 2'd0;
            f3_ok         = 1'b0;
         end
      endcase
   end

   assign o_alu_sub = is_op && (instr.r.funct7 == sercore_isa_pkg::F7_SUB) &&
                      (instr.r.funct3 == sercore_isa_pkg::F3_ADD);
   assign f7_ok     = (instr.r.funct7 == '0) || o_alu_sub;

   assign o_rs1_addr = instr.r.rs1;
   assign o_rs2_addr = instr.r.rs2;
   assign o_rd_addr  = instr.r.rd;
   assign o_op_b_imm = is_op_imm;
   // Bit 1 picks the immediate, bit 0 the link value
   assign o_rd_sel   = {is_lui, is_jal};
   assign o_jump     = is_jal;
   assign o_rd_write = (is_op && f3_ok && f7_ok) || (is_op_imm && f3_ok) || is_lui || is_jal;
   assign o_imm      = imm_sr[0];

endmodule

`default_nettype wire

// ==== source/sercore_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module sercore_alu (
   input  wire       clk,
   input  wire       i_arst_n,
   input  wire       i_cnt_en,
   input  wire       i_cnt0,
   input  wire       i_rs1,
   input  wire       i_rs2,
   input  wire       i_imm,
   input  wire       i_op_b_imm,
   input  wire       i_sub,
   input  wire [1:0] i_bool_op,
   output logic      o_rd
);

   logic op_b;
   logic b_add;
   logic cin;
   logic sum;
   logic carry;

   assign op_b  = i_op_b_imm ? i_imm : i_rs2;
   // Two's complement subtract, invert B and carry in a one
   assign b_add = op_b ^ i_sub;
   assign cin   = i_cnt0 ? i_sub : carry;
   assign sum   = i_rs1 ^ b_add ^ cin;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         carry <= 1'b0;
      end else if (i_cnt_en) begin
         carry <= (i_rs1 & b_add) | (cin & (i_rs1 ^ b_add));
      end
   end

   always_comb begin
      case (i_bool_op)
         2'd1:    o_rd = i_rs1 ^ op_b;
         2'd2:    o_rd = i_rs1 | op_b;
         2'd3:    o_rd = i_rs1 & op_b;
         default: o_rd = sum;
      endcase
   end

endmodule

`default_nettype wire

// ==== source/sercore_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sercore_ctrl #(
   parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
   input  wire                               clk,
   input  wire                               i_arst_n,
   input  wire                               i_cnt_en,
   input  wire                               i_cnt2,
   input  wire                               i_cnt_done,
   input  wire                               i_jump,
   input  wire                               i_imm,
   output logic                              o_rd,
   output logic [sercore_cfg_pkg::XLEN-1:0]  o_ibus_adr
);

   localparam int XLEN = sercore_cfg_pkg::XLEN;

   logic [XLEN-1:0] pc;
   logic            add_b;
   logic            new_pc;
   logic            carry_pc;
   logic            carry_link;

   // Jump target or PC+4
   assign add_b  = i_jump ? i_imm : i_cnt2;
   assign new_pc = pc[0] ^ add_b ^ carry_pc;

   // Link value, always PC+4
   assign o_rd = pc[0] ^ i_cnt2 ^ carry_link;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc         <= RESET_PC;
         carry_pc   <= 1'b0;
         carry_link <= 1'b0;
      end else if (i_cnt_en) begin
         // After 32 shifts the register holds the new PC
         pc         <= {new_pc, pc[XLEN-1:1]};
         carry_pc   <= !i_cnt_done && ((pc[0] & add_b) | (carry_pc & (pc[0] ^ add_b)));
         carry_link <= !i_cnt_done && ((pc[0] & i_cnt2) | (carry_link & (pc[0] ^ i_cnt2)));
      end
   end

   assign o_ibus_adr = pc;

endmodule

`default_nettype wire

// ==== source/sercore_rf_if.sv ====
`timescale 1ns/1ps
`default_nettype none

module sercore_rf_if (
   input  wire  [sercore_cfg_pkg::REG_AW-1:0] i_rs1_addr,
   input  wire  [sercore_cfg_pkg::REG_AW-1:0] i_rs2_addr,
   input  wire  [sercore_cfg_pkg::REG_AW-1:0] i_rd_addr,
   input  wire                                i_rd_en,
   input  wire  [1:0]                         i_rd_sel,
   input  wire                                i_alu_rd,
   input  wire                                i_ctrl_rd,
   input  wire                                i_imm,
   output logic [sercore_cfg_pkg::REG_AW-1:0] o_rreg0,
   output logic [sercore_cfg_pkg::REG_AW-1:0] o_rreg1,
   output logic [sercore_cfg_pkg::REG_AW-1:0] o_wreg,
   output logic                               o_wen,
   output logic                               o_wdata
);

   assign o_rreg0 = i_rs1_addr;
   assign o_rreg1 = i_rs2_addr;
   assign o_wreg  = i_rd_addr;

   // x0 is never written
   assign o_wen = i_rd_en && (i_rd_addr != '0);

   always_comb begin
      if (i_rd_sel[1]) begin
         o_wdata = i_imm;
      end else if (i_rd_sel[0]) begin
         o_wdata = i_ctrl_rd;
      end else begin
         o_wdata = i_alu_rd;
      end
   end

endmodule

`default_nettype wire

// ==== source/sercore_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sercore_top #(
   parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
   input  wire                                clk,
   input  wire                                i_arst_n,
   // Instruction bus
   output wire                                o_ibus_cyc,
   output wire [sercore_cfg_pkg::XLEN-1:0]    o_ibus_adr,
   input  wire [sercore_cfg_pkg::XLEN-1:0]    i_ibus_rdt,
   input  wire                                i_ibus_ack,
   // Register file
   output wire                                o_rf_rreq,
   output wire [sercore_cfg_pkg::REG_AW-1:0]  o_rreg0,
   output wire [sercore_cfg_pkg::REG_AW-1:0]  o_rreg1,
   input  wire                                i_rf_ready,
   input  wire                                i_rdata0,
   input  wire                                i_rdata1,
   output wire                                o_wen,
   output wire [sercore_cfg_pkg::REG_AW-1:0]  o_wreg,
   output wire                                o_wdata
);

   wire [sercore_cfg_pkg::REG_AW-1:0] rs1_addr;
   wire [sercore_cfg_pkg::REG_AW-1:0] rs2_addr;
   wire [sercore_cfg_pkg::REG_AW-1:0] rd_addr;
   wire                               cnt_start;
   wire                               cnt_en;
   wire                               cnt0;
   wire                               cnt2;
   wire                               cnt_done;
   wire                               rd_en;
   wire                               op_b_imm;
   wire                               alu_sub;
   wire [1:0]                         alu_bool_op;
   wire [1:0]                         rd_sel;
   wire                               jump;
   wire                               rd_write;
   wire                               imm;
   wire                               alu_rd;
   wire                               ctrl_rd;

   sercore_state state (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_ibus_ack(i_ibus_ack), .i_rf_ready(i_rf_ready),
      .i_cnt_done(cnt_done), .i_rd_write(rd_write),
      .o_ibus_cyc(o_ibus_cyc), .o_rf_rreq(o_rf_rreq),
      .o_cnt_start(cnt_start), .o_rd_en(rd_en)
   );

   sercore_count count (
      .clk(clk), .i_arst_n(i_arst_n), .i_start(cnt_start),
      .o_cnt_en(cnt_en), .o_cnt0(cnt0), .o_cnt2(cnt2), .o_cnt_done(cnt_done)
   );

   sercore_decode decode (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_ibus_ack(i_ibus_ack), .i_ibus_rdt(i_ibus_rdt), .i_cnt_en(cnt_en),
      .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_rd_addr(rd_addr),
      .o_op_b_imm(op_b_imm), .o_alu_sub(alu_sub), .o_alu_bool_op(alu_bool_op),
      .o_rd_sel(rd_sel), .o_jump(jump), .o_rd_write(rd_write), .o_imm(imm)
   );

   // Source bits come straight from the register file
   sercore_alu alu (
      .clk(clk), .i_arst_n(i_arst_n), .i_cnt_en(cnt_en), .i_cnt0(cnt0),
      .i_rs1(i_rdata0), .i_rs2(i_rdata1), .i_imm(imm),
      .i_op_b_imm(op_b_imm), .i_sub(alu_sub), .i_bool_op(alu_bool_op),
      .o_rd(alu_rd)
   );

   sercore_ctrl #(.RESET_PC(RESET_PC)) ctrl (
      .clk(clk), .i_arst_n(i_arst_n), .i_cnt_en(cnt_en), .i_cnt2(cnt2),
      .i_cnt_done(cnt_done), .i_jump(jump), .i_imm(imm),
      .o_rd(ctrl_rd), .o_ibus_adr(o_ibus_adr)
   );

   sercore_rf_if rf_if (
      .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr), .i_rd_addr(rd_addr),
      .i_rd_en(rd_en), .i_rd_sel(rd_sel),
      .i_alu_rd(alu_rd), .i_ctrl_rd(ctrl_rd), .i_imm(imm),
      .o_rreg0(o_rreg0), .o_rreg1(o_rreg1), .o_wreg(o_wreg),
      .o_wen(o_wen), .o_wdata(o_wdata)
   );

endmodule

`default_nettype wire

// ==== sim/sercore_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sercore_tb;

   localparam logic [31:0] RESET_PC  = 32'h0000_1000;
   localparam int          NUM_INSTR = 400;
   localparam int          TIMEOUT   = 40;

   logic        clk;
   logic        i_arst_n;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic        i_rf_ready;
   logic        i_rdata0;
   logic        i_rdata1;
   wire         o_ibus_cyc;
   wire  [31:0] o_ibus_adr;
   wire         o_rf_rreq;
   wire  [4:0]  o_rreg0;
   wire  [4:0]  o_rreg1;
   wire         o_wen;
   wire  [4:0]  o_wreg;
   wire         o_wdata;

   logic [31:0] rng;
   logic [31:0] rf_mem [32];
   logic [31:0] model_regs [32];
   logic [31:0] model_pc;
   int          mismatches;
   int          timeouts;
   int          retired;

   sercore_top #(.RESET_PC(RESET_PC)) UUT (
      .clk(clk), .i_arst_n(i_arst_n),
      .o_ibus_cyc(o_ibus_cyc), .o_ibus_adr(o_ibus_adr),
      .i_ibus_rdt(i_ibus_rdt), .i_ibus_ack(i_ibus_ack),
      .o_rf_rreq(o_rf_rreq), .o_rreg0(o_rreg0), .o_rreg1(o_rreg1),
      .i_rf_ready(i_rf_ready), .i_rdata0(i_rdata0), .i_rdata1(i_rdata1),
      .o_wen(o_wen), .o_wreg(o_wreg), .o_wdata(o_wdata)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32();
      logic [31:0] x;
      x   = rng;
      x   = x ^ (x << 13);
      x   = x ^ (x >> 17);
      x   = x ^ (x << 5);
      rng = x;
      return x;
   endfunction

   function automatic sercore_isa_pkg::instr_u make_instr();
      sercore_isa_pkg::instr_u w;
      logic [31:0]             r;
      logic [31:0]             off;
      logic [2:0]              f3;
      r   = xorshift32();
      w   = xorshift32();
      off = xorshift32();
      case (r[5:4])
         2'd0:    f3 = sercore_isa_pkg::F3_ADD;
         2'd1:    f3 = sercore_isa_pkg::F3_XOR;
         2'd2:    f3 = sercore_isa_pkg::F3_OR;
         default: f3 = sercore_isa_pkg::F3_AND;
      endcase
      if (r[3:0] <= 4'd4) begin
         w.r.opcode = sercore_isa_pkg::OPC_OP;
         w.r.funct3 = f3;
         w.r.funct7 = (f3 == sercore_isa_pkg::F3_ADD && r[6]) ? sercore_isa_pkg::F7_SUB : 7'h00;
      end else if (r[3:0] <= 4'd9) begin
         w.i.opcode = sercore_isa_pkg::OPC_OP_IMM;
         w.i.funct3 = f3;
      end else if (r[3:0] <= 4'd11) begin
         w.u.opcode = sercore_isa_pkg::OPC_LUI;
      end else if (r[3:0] <= 4'd13) begin
         // Word aligned J offset in imm[20|10:1|11|19:12] order
         w.u.opcode = sercore_isa_pkg::OPC_JAL;
         w.u.imm20  = {off[20], off[10:2], 1'b0, off[11], off[19:12]};
      end else begin
         case (r[5:4])
            2'd0:    w.r.opcode = 7'b0000011;
            2'd1:    w.r.opcode = 7'b0100011;
            2'd2:    w.r.opcode = 7'b1100011;
            default: w.r.opcode = 7'b0010111;
         endcase
      end
      // Extra weight on x0 as destination
      if (r[11:8] == 4'd0) begin
         w.r.rd = 5'd0;
      end
      return w;
   endfunction

   task automatic predict(input sercore_isa_pkg::instr_u w, output logic wen,
                          output logic [31:0] val, output logic [31:0] next_pc);
      logic [31:0] raw;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm_i;
      logic [31:0] imm_j;
      logic        writes;
      raw     = w;
      a       = model_regs[w.r.rs1];
      b       = model_regs[w.r.rs2];
      imm_i   = {{20{raw[31]}}, raw[31:20]};
      imm_j   = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
      writes  = 1'b1;
      val     = '0;
      next_pc = model_pc + 32'd4;
      case (w.r.opcode)
         sercore_isa_pkg::OPC_OP, sercore_isa_pkg::OPC_OP_IMM: begin
            if (w.r.opcode == sercore_isa_pkg::OPC_OP_IMM) begin
               b = imm_i;
            end
            case (w.r.funct3)
               sercore_isa_pkg::F3_ADD: begin
                  if (w.r.opcode == sercore_isa_pkg::OPC_OP &&
                      w.r.funct7 == sercore_isa_pkg::F7_SUB) begin
                     val = a - b;
                  end else begin
                     val = a + b;
                  end
               end
               sercore_isa_pkg::F3_XOR: val = a ^ b;
               sercore_isa_pkg::F3_OR:  val = a | b;
               sercore_isa_pkg::F3_AND: val = a & b;
               default:                 writes = 1'b0;
            endcase
         end
         sercore_isa_pkg::OPC_LUI: val = {raw[31:12], 12'h000};
         sercore_isa_pkg::OPC_JAL: begin
            val     = model_pc + 32'd4;
            next_pc = model_pc + imm_j;
         end
         default: writes = 1'b0;
      endcase
      wen = writes && (w.r.rd != 5'd0);
   endtask

   task automatic report_mismatch(input string msg);
      $display("Mismatch at %0t ns: %s", $time, msg);
      mismatches++;
   endtask

   task automatic check_quiet(input string where);
      if (o_rf_rreq !== 1'b0 || o_wen !== 1'b0) begin
         report_mismatch($sformatf("read request or write enable high %s", where));
      end
   endtask

   task automatic wait_fetch();
      int t;
      t = 0;
      @(negedge clk);
      while (o_ibus_cyc !== 1'b1 && t < TIMEOUT) begin
         check_quiet("before fetch");
         @(negedge clk);
         t++;
      end
      if (o_ibus_cyc !== 1'b1) begin
         $display("Timeout at %0t ns: the core never started the next fetch", $time);
         timeouts++;
      end
   endtask

   task automatic wait_rreq();
      int t;
      t = 0;
      @(negedge clk);
      while (o_rf_rreq !== 1'b1 && t < TIMEOUT) begin
         @(negedge clk);
         t++;
      end
      if (o_rf_rreq !== 1'b1) begin
         $display("Timeout at %0t ns: no register read request after ack", $time);
         timeouts++;
      end
   endtask

   task automatic run_instr();
      sercore_isa_pkg::instr_u w;
      logic                    exp_wen;
      logic [31:0]             exp_val;
      logic [31:0]             exp_pc;
      logic [31:0]             a;
      logic [31:0]             b;
      logic [31:0]             got;
      logic                    got_wen;
      logic [4:0]              ra;
      logic [4:0]              rb;
      logic [4:0]              wa;
      int                      dly;
      int                      k;
      wait_fetch();
      if (timeouts != 0) begin
         return;
      end
      if (o_ibus_adr !== model_pc) begin
         report_mismatch($sformatf("fetch address %h, expected %h", o_ibus_adr, model_pc));
      end
      w = make_instr();
      predict(w, exp_wen, exp_val, exp_pc);
      dly = xorshift32() % 6;
      repeat (dly) begin
         @(negedge clk);
         check_quiet("while waiting for ack");
         if (o_ibus_cyc !== 1'b1 || o_ibus_adr !== model_pc) begin
            report_mismatch("bus cycle or address changed before ack");
         end
      end
      @(posedge clk);
      i_ibus_ack <= 1'b1;
      i_ibus_rdt <= w;
      @(posedge clk);
      i_ibus_ack <= 1'b0;
      i_ibus_rdt <= xorshift32();
      wait_rreq();
      if (timeouts != 0) begin
         return;
      end
      ra = o_rreg0;
      rb = o_rreg1;
      if (ra !== w.r.rs1 || rb !== w.r.rs2) begin
         report_mismatch($sformatf("read addresses x%0d x%0d, expected x%0d x%0d",
                                   ra, rb, w.r.rs1, w.r.rs2));
      end
      if (o_ibus_cyc !== 1'b0) begin
         report_mismatch("bus cycle still high after ack");
      end
      dly = xorshift32() % 6;
      repeat (dly) begin
         @(negedge clk);
         if (o_wen !== 1'b0 || o_rreg0 !== ra || o_rreg1 !== rb) begin
            report_mismatch("read addresses moved or write enable high before ready");
         end
         if (o_rf_rreq !== 1'b0 || o_ibus_cyc !== 1'b0) begin
            report_mismatch("read request or bus cycle high while waiting for ready");
         end
      end
      a = rf_mem[ra];
      b = rf_mem[rb];
      @(posedge clk);
      i_rf_ready <= 1'b1;
      @(posedge clk);
      i_rf_ready <= 1'b0;
      got     = '0;
      got_wen = 1'b0;
      wa      = '0;
      // Bit k of each source in execute cycle k
      for (k = 0; k < 32; k++) begin
         i_rdata0 <= a[k];
         i_rdata1 <= b[k];
         @(negedge clk);
         if (o_wen !== exp_wen) begin
            report_mismatch($sformatf("write enable %b in bit %0d, expected %b",
                                      o_wen, k, exp_wen));
         end
         if (o_wen === 1'b1 && o_wreg !== w.r.rd) begin
            report_mismatch($sformatf("write address x%0d, expected x%0d", o_wreg, w.r.rd));
         end
         if (o_rf_rreq !== 1'b0 || o_ibus_cyc !== 1'b0) begin
            report_mismatch($sformatf("read request or bus cycle high in bit %0d", k));
         end
         if (o_wen === 1'b1) begin
            got_wen = 1'b1;
            wa      = o_wreg;
         end
         got[k] = o_wdata;
         @(posedge clk);
      end
      i_rdata0 <= 1'b0;
      i_rdata1 <= 1'b0;
      if (exp_wen && got !== exp_val) begin
         report_mismatch($sformatf("x%0d written with %h, expected %h", w.r.rd, got, exp_val));
      end
      // Register file commits after bit 31
      if (got_wen && wa != 5'd0) begin
         rf_mem[wa] = got;
      end
      if (exp_wen) begin
         model_regs[w.r.rd] = exp_val;
      end
      model_pc = exp_pc;
      retired++;
   endtask

   initial begin
      int i;
      rng        = 32'h775e;
      mismatches = 0;
      timeouts   = 0;
      retired    = 0;
      i_arst_n   <= 1'b0;
      i_ibus_rdt <= '0;
      i_ibus_ack <= 1'b0;
      i_rf_ready <= 1'b0;
      i_rdata0   <= 1'b0;
      i_rdata1   <= 1'b0;
      for (i = 0; i < 32; i++) begin
         rf_mem[i]     = (i == 0) ? 32'h0 : xorshift32();
         model_regs[i] = rf_mem[i];
      end
      model_pc = RESET_PC;
      for (i = 0; i < 10; i++) begin
         @(negedge clk);
         if (o_ibus_cyc !== 1'b0 || o_rf_rreq !== 1'b0 || o_wen !== 1'b0) begin
            report_mismatch("outputs active during reset");
         end
      end
      @(posedge clk);
      i_arst_n <= 1'b1;
      for (i = 0; i < NUM_INSTR && timeouts == 0; i++) begin
         run_instr();
      end
      $display("Retired %0d instructions, %0d mismatches, %0d timeouts",
               retired, mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sercore.f ====
source/sercore_cfg_pkg.sv
source/sercore_isa_pkg.sv
source/sercore_state.sv
source/sercore_count.sv
source/sercore_decode.sv
source/sercore_alu.sv
source/sercore_ctrl.sv
source/sercore_rf_if.sv
source/sercore_top.sv
sim/sercore_tb.sv

// ==== Bender.yml ====
package:
  name: sercore

sources:
  # Packages first, then the RTL bottom up
  - source/sercore_cfg_pkg.sv
  - source/sercore_isa_pkg.sv
  - source/sercore_state.sv
  - source/sercore_count.sv
  - source/sercore_decode.sv
  - source/sercore_alu.sv
  - source/sercore_ctrl.sv
  - source/sercore_rf_if.sv
  - source/sercore_top.sv
  - target: test
    files:
      - sim/sercore_tb.sv
